// File: rtl/ww_pkg.sv
package ww_pkg;

	localparam int WORD_W = 16;
	localparam int ADDR_W = 11;
	localparam int OP_W = 5;
	localparam int TP_COUNT = 8;	// Time pulses per instruction

	localparam logic [ADDR_W-1:0] MEM_BASE = 11'o3740;
	localparam int MEM_WORDS = 32;
	localparam int FF_WORDS = 5;	// Writable words at the bottom
	localparam int MEM_IDX_W = 5;

	// APB byte offsets
	localparam logic [7:0] REG_CONTROL = 8'h00;
	localparam logic [7:0] REG_STATUS = 8'h04;
	localparam logic [7:0] REG_AC = 8'h08;
	localparam logic [7:0] REG_PC = 8'h0C;
	localparam logic [7:0] MEM_WINDOW = 8'h80;

	typedef enum logic [OP_W-1:0] {
		op_halt = 5'o00,
		op_ts = 5'o10,	// Transfer to storage
		op_td = 5'o11,	// Transfer digits into the address part
		op_cp = 5'o16,	// Conditional program
		op_sp = 5'o17,	// Unconditional subprogram jump
		op_ca = 5'o20,
		op_cs = 5'o21,
		op_ad = 5'o22,
		op_su = 5'o23
	} ww_op_t;

	typedef struct packed {
		ww_op_t op;
		logic [ADDR_W-1:0] addr;
	} ww_instr_t;

	typedef struct packed {
		logic sign;
		logic [WORD_W-2:0] mag;
	} ww_data_t;

	// Same word seen as an order or as a number
	typedef union packed {
		ww_instr_t instr;
		ww_data_t data;
	} ww_word_t;

	typedef struct packed {
		logic wr;
		logic addr_only;	// Only the low 11 bits change
		logic [ADDR_W-1:0] addr;
		ww_word_t data;
	} mem_req_t;

	typedef struct packed {
		logic wr;
		logic [MEM_IDX_W-1:0] idx;
		ww_word_t data;
	} panel_mem_t;

	typedef struct packed {
		logic go;
		ww_op_t op;
		ww_word_t operand;
	} ae_cmd_t;

endpackage

// File: rtl/ww_control_panel.sv
`timescale 1ns/1ps

module ww_control_panel import ww_pkg::*; (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [7:0] paddr,
	input logic [WORD_W-1:0] pwdata,
	output logic [WORD_W-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic running,
	input logic alarm,
	input ww_word_t ac,
	input logic [ADDR_W-1:0] pc,
	output logic start,
	output logic [ADDR_W-1:0] start_pc,
	output panel_mem_t mem,
	input ww_word_t mem_rdata
);
	logic access;
	logic is_mem;
	logic is_ctrl;
	logic is_ro;
	logic err;
	logic wr_ok;
	logic [7:0] mem_off;
	logic [ADDR_W-1:0] start_sw;	// Start address switches

	assign access = psel && penable;
	assign mem_off = paddr - MEM_WINDOW;
	assign is_mem = (paddr >= MEM_WINDOW) && (paddr[1:0] == 2'b00);
	assign is_ctrl = paddr == REG_CONTROL;
	assign is_ro = paddr inside {REG_STATUS, REG_AC, REG_PC};

	// Bad address, read only target, or panel write while the machine runs
	assign err = !(is_mem || is_ctrl || is_ro) ||
		(pwrite && is_ro) ||
		(pwrite && running && (is_ctrl || is_mem));

	assign pready = 1'b1;	// Never waits
	assign pslverr = access && err;
	assign wr_ok = access && pwrite && !err;

	assign start = wr_ok && is_ctrl;	// One cycle in the access phase
	assign start_pc = pwdata[ADDR_W-1:0];

	assign mem.wr = wr_ok && is_mem;
	assign mem.idx = mem_off[MEM_IDX_W+1:2];
	assign mem.data = pwdata;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			start_sw <= '0;
		end else if (start) begin
			start_sw <= start_pc;
		end
	end

	always_comb begin
		prdata = '0;
		if (is_mem) begin
			prdata = mem_rdata;
		end else begin
			case (paddr)
				REG_CONTROL: prdata = {{(WORD_W-ADDR_W){1'b0}}, start_sw};
				REG_STATUS: prdata = {{(WORD_W-2){1'b0}}, alarm, running};
				REG_AC: prdata = ac;
				REG_PC: prdata = {{(WORD_W-ADDR_W){1'b0}}, pc};
				default: prdata = '0;
			endcase
		end
	end

endmodule

// File: rtl/ww_sequencer.sv
`timescale 1ns/1ps

module ww_sequencer import ww_pkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input logic [ADDR_W-1:0] start_pc,
	output mem_req_t mem,
	input ww_word_t mem_rdata,
	output ae_cmd_t cmd,
	input ww_word_t ac,
	input logic overflow,
	output logic running,
	output logic alarm,
	output logic [ADDR_W-1:0] pc
);
	logic [$clog2(TP_COUNT)-1:0] tp_cnt;
	logic [TP_COUNT-1:0] tp;	// tp[0] is tp1
	logic lead;	// Idle cycle between start and tp1
	logic [ADDR_W-1:0] ss;	// Storage switch address
	ww_word_t pr;	// Program register
	ww_op_t op;
	logic is_arith;
	logic is_store;
	logic is_jump;
	logic stop_op;

	assign tp = (running && !lead) ? (TP_COUNT'(1) << tp_cnt) : '0;

	// Control switch decode
	assign op = pr.instr.op;
	assign is_arith = op inside {op_ca, op_cs, op_ad, op_su};
	assign is_store = op inside {op_ts, op_td};
	assign is_jump = (op == op_sp) || (op == op_cp && ac.data.sign);	// cp on negative ac
	assign stop_op = !(is_arith || is_store || op inside {op_cp, op_sp});	// halt or unknown

	assign mem.wr = tp[5] && is_store;
	assign mem.addr_only = op == op_td;
	assign mem.addr = ss;
	assign mem.data = ac;

	assign cmd.go = tp[5] && is_arith;
	assign cmd.op = op;
	assign cmd.operand = mem_rdata;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			running <= 1'b0;
			alarm <= 1'b0;
			lead <= 1'b0;
			tp_cnt <= '0;
			pc <= '0;
			ss <= '0;
			pr <= '0;
		end else if (start) begin
			running <= 1'b1;
			alarm <= 1'b0;
			lead <= 1'b1;
			tp_cnt <= '0;
			pc <= start_pc;
		end else if (running) begin
			lead <= 1'b0;
			if (!lead) begin
				tp_cnt <= tp_cnt + 1'b1;	// Wraps back to tp1 after tp8
			end
			if (tp[0]) begin
				ss <= pc;
			end
			if (tp[1]) begin
				pr <= mem_rdata;
				pc <= pc + 1'b1;
			end
			if (tp[3]) begin
				ss <= pr.instr.addr;	// Operand address
			end
			if (tp[5] && is_jump) begin
				pc <= pr.instr.addr;
			end
			if (tp[5] && overflow) begin
				alarm <= 1'b1;
			end
			// Alarm raised at tp6 also stops the machine here
			if (tp[7] && (stop_op || alarm)) begin
				running <= 1'b0;
			end
		end
	end

endmodule

// File: rtl/ww_storage.sv
`timescale 1ns/1ps

module ww_storage import ww_pkg::*; (
	input logic clk,
	input logic reset,
	input mem_req_t req,
	output ww_word_t rdata,
	input panel_mem_t panel,
	output ww_word_t panel_rdata
);
	ww_word_t mem [MEM_WORDS];	// Flip-flop words first, then toggle switches
	logic [ADDR_W-1:0] offset;
	logic [MEM_IDX_W-1:0] prog_idx;
	logic in_range;
	logic prog_we;

	// Storage switch decode
	assign offset = req.addr - MEM_BASE;
	assign in_range = offset[ADDR_W-1:MEM_IDX_W] == '0;
	assign prog_idx = offset[MEM_IDX_W-1:0];
	assign prog_we = req.wr && in_range && (prog_idx < MEM_IDX_W'(FF_WORDS));

	assign rdata = in_range ? mem[prog_idx] : '0;
	assign panel_rdata = mem[panel.idx];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < FF_WORDS; i++) begin
				mem[i] <= '0;	// Flip-flop storage clears to zero
			end
		end else if (panel.wr) begin
			mem[panel.idx] <= panel.data;
		end else if (prog_we) begin
			if (req.addr_only) begin
				mem[prog_idx].instr.addr <= req.data.instr.addr;	// td keeps the op field
			end else begin
				mem[prog_idx] <= req.data;
			end
		end
	end

endmodule

// File: rtl/ww_arith.sv
`timescale 1ns/1ps

module ww_arith import ww_pkg::*; (
	input logic clk,
	input logic reset,
	input ae_cmd_t cmd,
	output ww_word_t ac,
	output logic overflow
);
	logic is_load;
	logic is_add;
	logic negate;
	logic [WORD_W-1:0] addend;
	logic [WORD_W:0] raw_sum;
	logic [WORD_W-1:0] sum;

	assign is_load = cmd.op inside {op_ca, op_cs};
	assign is_add = cmd.op inside {op_ad, op_su};
	assign negate = cmd.op inside {op_cs, op_su};	// Ones' complement negation
	assign addend = negate ? ~cmd.operand : cmd.operand;

	assign raw_sum = {1'b0, ac} + {1'b0, addend};
	// End-around carry never carries twice
	assign sum = raw_sum[WORD_W-1:0] + {{(WORD_W-1){1'b0}}, raw_sum[WORD_W]};

	// Like signs in, other sign out
	assign overflow = cmd.go && is_add &&
		(ac.data.sign == addend[WORD_W-1]) &&
		(sum[WORD_W-1] != ac.data.sign);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			ac <= '0;
		end else if (cmd.go && is_load) begin
			ac <= addend;
		end else if (cmd.go && is_add) begin
			ac <= sum;	// Wrapped sum kept on overflow
		end
	end

endmodule

// File: rtl/ww_top.sv
`timescale 1ns/1ps

module ww_top import ww_pkg::*; (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [7:0] paddr,
	input logic [WORD_W-1:0] pwdata,
	output logic [WORD_W-1:0] prdata,
	output logic pready,
	output logic pslverr
);
	logic start;
	logic [ADDR_W-1:0] start_pc;
	logic running;
	logic alarm;
	logic [ADDR_W-1:0] pc;
	ww_word_t ac;
	logic overflow;
	mem_req_t mem_req;
	ww_word_t mem_rdata;
	panel_mem_t panel_mem;
	ww_word_t panel_rdata;
	ae_cmd_t cmd;

	ww_control_panel u_panel (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.running(running),
		.alarm(alarm),
		.ac(ac),
		.pc(pc),
		.start(start),
		.start_pc(start_pc),
		.mem(panel_mem),
		.mem_rdata(panel_rdata)
	);

	ww_sequencer u_seq (
		.clk(clk),
		.reset(reset),
		.start(start),
		.start_pc(start_pc),
		.mem(mem_req),
		.mem_rdata(mem_rdata),
		.cmd(cmd),
		.ac(ac),
		.overflow(overflow),
		.running(running),
		.alarm(alarm),
		.pc(pc)
	);

	ww_storage u_storage (
		.clk(clk),
		.reset(reset),
		.req(mem_req),
		.rdata(mem_rdata),
		.panel(panel_mem),
		.panel_rdata(panel_rdata)
	);

	ww_arith u_arith (
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.ac(ac),
		.overflow(overflow)
	);

endmodule

// File: verif/ww_assertions.sv
`timescale 1ns/1ps

module ww_assertions (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr,
	input logic running
);
	// Slave never inserts wait states
	assert property (@(posedge clk) disable iff (!reset) psel |-> pready)
		else $error("pready low while the slave is selected");

	assert property (@(posedge clk) disable iff (!reset) pslverr |-> psel && penable)
		else $error("pslverr raised outside an access cycle");

	assert property (@(posedge clk) $rose(reset) |-> !running)
		else $error("running high in the first cycle after reset");

endmodule

// File: verif/ww_tb.sv
`timescale 1ns/1ps

module ww_tb import ww_pkg::*; ();
	logic clk = 1'b0;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [WORD_W-1:0] pwdata;
	logic [WORD_W-1:0] prdata;
	logic pready;
	logic pslverr;
	int seed = 83418;
	int errors = 0;
	int cycles = 0;
	int prog_count = 50;
	int cycle_limit;
	logic [WORD_W-1:0] model_mem [MEM_WORDS];	// Reference storage
	logic [WORD_W-1:0] model_ac;
	logic [ADDR_W-1:0] model_pc;
	logic model_alarm;
	ww_op_t kept_ops [8] = '{op_ts, op_td, op_cp, op_sp, op_ca, op_cs, op_ad, op_su};

	ww_top dut (.*);

	bind ww_top ww_assertions u_assertions (
		.clk(clk), .reset(reset), .psel(psel), .penable(penable),
		.pready(pready), .pslverr(pslverr), .running(running)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout: the machine gave no result within %0d cycles", cycle_limit);
			$display(">>> FAIL");
			$finish;
		end
	end

	function automatic int unsigned rnd(input int unsigned range);
		int unsigned v;
		v = $random(seed);
		return v % range;
	endfunction

	task automatic compare(input string name, input logic [WORD_W-1:0] actual,
		input logic [WORD_W-1:0] expected);
		if (actual !== expected) begin
			errors++;
			$display("Mismatch %s: got %h, expected %h at %0t", name, actual, expected, $time);
		end
	endtask

	task automatic apb(input logic wr, input logic [7:0] addr, input logic [WORD_W-1:0] wdata,
		input logic exp_err, output logic [WORD_W-1:0] rdata);
		@(posedge clk);
		#1;
		{psel, penable, pwrite, paddr, pwdata} = {1'b1, 1'b0, wr, addr, wdata};	// Setup
		@(posedge clk);
		#1;
		penable = 1'b1;
		#8;
		rdata = prdata;	// Mid access cycle
		compare("pslverr", WORD_W'(pslverr), WORD_W'(exp_err));
	endtask

	task automatic read_check(input string name, input logic [7:0] addr,
		input logic [WORD_W-1:0] expected);
		logic [WORD_W-1:0] data;
		apb(1'b0, addr, '0, 1'b0, data);
		compare(name, data, expected);
	endtask

	function automatic logic [WORD_W-1:0] model_word(input logic [ADDR_W-1:0] addr);
		logic [ADDR_W-1:0] off;
		off = addr - MEM_BASE;
		if (off < ADDR_W'(MEM_WORDS)) begin
			return model_mem[off[MEM_IDX_W-1:0]];
		end
		return '0;	// Outside storage
	endfunction

	task automatic run_model(input logic [ADDR_W-1:0] start_addr);
		logic [WORD_W-1:0] word;
		logic [WORD_W-1:0] operand;
		logic [WORD_W-1:0] addend;
		logic [WORD_W:0] raw;
		logic [OP_W-1:0] op;
		logic [ADDR_W-1:0] off;
		logic done;
		model_pc = start_addr;
		model_alarm = 1'b0;
		done = 1'b0;
		while (!done) begin
			word = model_word(model_pc);
			model_pc = model_pc + 1'b1;
			op = word[WORD_W-1:ADDR_W];
			operand = model_word(word[ADDR_W-1:0]);
			off = word[ADDR_W-1:0] - MEM_BASE;
			case (op)
				op_ca: model_ac = operand;
				op_cs: model_ac = ~operand;
				op_ad, op_su: begin
					addend = (op == op_su) ? ~operand : operand;
					raw = {1'b0, model_ac} + {1'b0, addend};
					raw[WORD_W-1:0] = raw[WORD_W-1:0] + WORD_W'(raw[WORD_W]);	// End-around carry
					model_alarm = (model_ac[WORD_W-1] == addend[WORD_W-1]) &&
						(raw[WORD_W-1] != addend[WORD_W-1]);
					model_ac = raw[WORD_W-1:0];
					done = model_alarm;
				end
				op_ts, op_td: begin
					if (off < ADDR_W'(FF_WORDS) && op == op_ts) begin
						model_mem[off[MEM_IDX_W-1:0]] = model_ac;
					end else if (off < ADDR_W'(FF_WORDS)) begin
						model_mem[off[MEM_IDX_W-1:0]][ADDR_W-1:0] = model_ac[ADDR_W-1:0];
					end
				end
				op_cp: begin
					if (model_ac[WORD_W-1]) begin
						model_pc = word[ADDR_W-1:0];
					end
				end
				op_sp: model_pc = word[ADDR_W-1:0];
				default: done = 1'b1;	// halt and unknown codes
			endcase
		end
	endtask

	task automatic run_program();
		int n;
		ww_op_t op;
		logic [ADDR_W-1:0] target;
		logic [ADDR_W-1:0] start_addr;
		logic [WORD_W-1:0] rd;
		n = 1 + rnd(MEM_WORDS - FF_WORDS - 1);	// Orders before the halt
		start_addr = MEM_BASE + ADDR_W'(FF_WORDS);
		for (int i = 0; i < MEM_WORDS; i++) begin
			model_mem[i] = WORD_W'(rnd(32'h10000));
		end
		for (int i = 0; i < n; i++) begin
			op = kept_ops[rnd(8)];
			target = ADDR_W'(rnd(MEM_WORDS));
			if (op inside {op_cp, op_sp}) begin
				target = ADDR_W'(FF_WORDS + i + 1 + rnd(n - i));	// Forward only
			end
			model_mem[FF_WORDS + i] = {op, MEM_BASE + target};
		end
		model_mem[FF_WORDS + n] = {op_halt, MEM_BASE};
		for (int i = 0; i < MEM_WORDS; i++) begin
			apb(1'b1, MEM_WINDOW + 8'(i * 4), model_mem[i], 1'b0, rd);
		end
		apb(1'b1, REG_CONTROL, WORD_W'(start_addr), 1'b0, rd);
		read_check("status", REG_STATUS, 16'h0001);	// Running with alarm cleared
		apb(1'b1, MEM_WINDOW, ~model_mem[0], 1'b1, rd);
		apb(1'b1, REG_CONTROL, '0, 1'b1, rd);
		run_model(start_addr);
		rd = 16'h0001;
		while (rd[0]) begin
			apb(1'b0, REG_STATUS, '0, 1'b0, rd);
		end
		compare("status", rd, {14'b0, model_alarm, 1'b0});
		read_check("ac", REG_AC, model_ac);
		read_check("pc", REG_PC, WORD_W'(model_pc));
		read_check("control", REG_CONTROL, WORD_W'(start_addr));
		for (int i = 0; i < MEM_WORDS; i++) begin
			read_check($sformatf("mem[%0d]", i), MEM_WINDOW + 8'(i * 4), model_mem[i]);
		end
	endtask

	initial begin
		logic [WORD_W-1:0] rd;
		cycle_limit = prog_count * ((MEM_WORDS - FF_WORDS) * TP_COUNT + 160) * 2;
		{reset, psel, penable, pwrite, paddr, pwdata} = '0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b1;
		model_ac = '0;
		read_check("status", REG_STATUS, '0);
		read_check("ac", REG_AC, '0);
		read_check("pc", REG_PC, '0);
		for (int i = 0; i < FF_WORDS; i++) begin
			read_check($sformatf("mem[%0d]", i), MEM_WINDOW + 8'(i * 4), '0);
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			model_mem[i] = WORD_W'(rnd(32'h10000));
			apb(1'b1, MEM_WINDOW + 8'(i * 4), model_mem[i], 1'b0, rd);
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			read_check($sformatf("mem[%0d]", i), MEM_WINDOW + 8'(i * 4), model_mem[i]);
		end
		apb(1'b0, 8'h10, '0, 1'b1, rd);	// Hole in the map
		apb(1'b1, 8'h82, ~model_mem[0], 1'b1, rd);	// Misaligned storage address
		apb(1'b1, REG_AC, 16'hffff, 1'b1, rd);
		read_check("mem[0]", MEM_WINDOW, model_mem[0]);
		read_check("ac", REG_AC, '0);
		for (int p = 0; p < prog_count; p++) begin
			run_program();
		end
		$display("Checks done: %0d errors", errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: list.f
rtl/ww_pkg.sv
rtl/ww_control_panel.sv
rtl/ww_sequencer.sv
rtl/ww_storage.sv
rtl/ww_arith.sv
rtl/ww_top.sv
verif/ww_assertions.sv
verif/ww_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= ww_tb
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR, TOP, OBJ_DIR, VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f list.f
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
